// File: cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W    = 16; // Data and address width
	localparam int REG_SEL_W = 4;  // Register index width

	// Bit positions in the flag word
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// Opcode 7 is unused, so it makes a side-effect free no-op
	localparam logic [WORD_W-1:0] NOP_WORD = 16'h7000;

	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		XOR = 4'h2,
		AND = 4'h3,
		SLL = 4'h4,
		SRA = 4'h5,
		ROR = 4'h6,
		LW  = 4'h8,
		SW  = 4'h9,
		LHB = 4'ha,
		LLB = 4'hb,
		B   = 4'hc,
		BR  = 4'hd,
		PCS = 4'he,
		HLT = 4'hf
	} opcode_t;

	typedef enum logic [1:0] {
		FWD_REG = 2'd0, // Value read in decode
		FWD_WB  = 2'd1, // MEM/WB result
		FWD_MEM = 2'd2  // EX/MEM result
	} fwd_sel_t;

endpackage

// File: stage_if.sv
`timescale 1ns/100ps

// Decode to execute
interface id_ex_if;
	logic [cpu_pkg::WORD_W-1:0]    pc_plus_2;
	logic [cpu_pkg::WORD_W-1:0]    instr;
	logic [cpu_pkg::WORD_W-1:0]    data_a;     // Port 1 read
	logic [cpu_pkg::WORD_W-1:0]    data_b;     // Port 2 read
	logic [cpu_pkg::REG_SEL_W-1:0] rs_sel;
	logic [cpu_pkg::REG_SEL_W-1:0] rt_sel;
	logic [cpu_pkg::REG_SEL_W-1:0] rd_sel;
	logic                          reg_write;
	logic                          mem_to_reg; // Load
	logic                          mem_write;  // Store

	modport source (output pc_plus_2, instr, data_a, data_b, rs_sel, rt_sel, rd_sel,
		reg_write, mem_to_reg, mem_write);
	modport sink (input pc_plus_2, instr, data_a, data_b, rs_sel, rt_sel, rd_sel,
		reg_write, mem_to_reg, mem_write);
endinterface

// Execute to memory
interface ex_mem_if;
	logic [cpu_pkg::WORD_W-1:0]    result;     // ALU, LHB/LLB or PCS value
	logic [cpu_pkg::WORD_W-1:0]    store_data;
	logic [cpu_pkg::WORD_W-1:0]    mem_addr;
	logic [cpu_pkg::REG_SEL_W-1:0] rd_sel;
	logic                          reg_write;
	logic                          mem_to_reg;
	logic                          mem_write;

	modport source (output result, store_data, mem_addr, rd_sel, reg_write, mem_to_reg,
		mem_write);
	modport sink (input result, store_data, mem_addr, rd_sel, reg_write, mem_to_reg,
		mem_write);
endinterface

// Writeback into the register file and the forwarding paths
interface wb_if;
	logic                          reg_write;
	logic [cpu_pkg::REG_SEL_W-1:0] rd_sel;
	logic [cpu_pkg::WORD_W-1:0]    value;

	modport source (output reg_write, rd_sel, value);
	modport sink (input reg_write, rd_sel, value);
endinterface

// File: fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       stall,
	input  logic                       flush,
	input  logic                       halted,
	input  logic                       branch_taken,
	input  logic [cpu_pkg::WORD_W-1:0] branch_target,
	input  logic [cpu_pkg::WORD_W-1:0] imem_data,
	output logic [cpu_pkg::WORD_W-1:0] imem_addr,
	output logic [cpu_pkg::WORD_W-1:0] pc_out,
	output logic [cpu_pkg::WORD_W-1:0] if_pc_plus_2,
	output logic [cpu_pkg::WORD_W-1:0] if_instr
);

	logic [cpu_pkg::WORD_W-1:0] pc;
	logic [cpu_pkg::WORD_W-1:0] pc_plus_2;

	assign pc_plus_2 = pc + cpu_pkg::WORD_W'(2);
	assign imem_addr = pc; // Zero-latency instruction read
	assign pc_out    = pc;

	// --------------------------------------------------
	// PC register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (branch_taken)
			pc <= branch_target; // Redirect from EX wins
		else if (!stall && !halted)
			pc <= pc_plus_2;
	end

	// --------------------------------------------------
	// IF/ID register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || flush)
			if_instr <= cpu_pkg::NOP_WORD; // Cancel wrong-path fetch
		else if (!stall)
			if_instr <= halted ? cpu_pkg::NOP_WORD : imem_data;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			if_pc_plus_2 <= pc_plus_2;
	end

	// Halfword aligned, redirect targets included
	assert property (@(posedge clk) disable iff (rst) !pc[0])
		else $error("PC not halfword aligned: %h", pc);

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage #(
	parameter int NUM_REGS = 16,
	parameter bit R0_ZERO  = 1'b1
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          stall,
	input  logic                          flush,
	input  logic [cpu_pkg::WORD_W-1:0]    if_pc_plus_2,
	input  logic [cpu_pkg::WORD_W-1:0]    if_instr,
	wb_if.sink                            wb,
	id_ex_if.source                       ide,
	output logic [cpu_pkg::REG_SEL_W-1:0] rs_sel,
	output logic [cpu_pkg::REG_SEL_W-1:0] rt_sel
);

	localparam int IDX_W = $clog2(NUM_REGS);

	cpu_pkg::opcode_t           op;
	logic [cpu_pkg::WORD_W-1:0] regs [NUM_REGS];
	logic [cpu_pkg::WORD_W-1:0] read_a, read_b;
	logic                       reg_write, mem_to_reg, mem_write;

	assign op = cpu_pkg::opcode_t'(if_instr[15:12]);

	// Port 1 takes rd for SW/LHB/LLB, port 2 takes the base for LW/SW
	assign rs_sel = (op == cpu_pkg::SW || op == cpu_pkg::LHB || op == cpu_pkg::LLB) ?
		if_instr[11:8] : if_instr[7:4];
	assign rt_sel = (op == cpu_pkg::LW || op == cpu_pkg::SW) ? if_instr[7:4] : if_instr[3:0];

	// --------------------------------------------------
	// Control bits
	// --------------------------------------------------
	always_comb begin
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		mem_write  = 1'b0;
		case (op)
			cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::XOR, cpu_pkg::AND,
			cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR,
			cpu_pkg::LHB, cpu_pkg::LLB, cpu_pkg::PCS: reg_write = 1'b1;
			cpu_pkg::LW: begin
				reg_write  = 1'b1;
				mem_to_reg = 1'b1;
			end
			cpu_pkg::SW: mem_write = 1'b1;
			default: ; // B, BR, HLT, no-op
		endcase
	end

	// --------------------------------------------------
	// Register file, write first
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wb.reg_write)
			regs[wb.rd_sel[IDX_W-1:0]] <= wb.value;
	end

	function automatic logic [cpu_pkg::WORD_W-1:0] read_port(
		input logic [cpu_pkg::REG_SEL_W-1:0] sel
	);
		logic [IDX_W-1:0] idx;
		idx = sel[IDX_W-1:0];
		if (R0_ZERO && idx == '0)
			return '0;
		if (wb.reg_write && wb.rd_sel[IDX_W-1:0] == idx)
			return wb.value; // Same-cycle writeback bypass
		return regs[idx];
	endfunction

	always_comb begin
		read_a = read_port(rs_sel);
		read_b = read_port(rt_sel);
	end

	// --------------------------------------------------
	// ID/EX register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || stall || flush) begin // Bubble
			ide.instr      <= cpu_pkg::NOP_WORD;
			ide.reg_write  <= 1'b0;
			ide.mem_to_reg <= 1'b0;
			ide.mem_write  <= 1'b0;
		end else begin
			ide.instr      <= if_instr;
			ide.reg_write  <= reg_write;
			ide.mem_to_reg <= mem_to_reg;
			ide.mem_write  <= mem_write;
		end
	end

	always_ff @(posedge clk) begin
		ide.pc_plus_2 <= if_pc_plus_2;
		ide.data_a    <= read_a;
		ide.data_b    <= read_b;
		ide.rs_sel    <= rs_sel;
		ide.rt_sel    <= rt_sel;
		ide.rd_sel    <= if_instr[11:8];
	end

	// A no-op in EX, bubble or cancelled fetch, never writes anything
	assert property (@(posedge clk) disable iff (rst)
		(ide.instr == cpu_pkg::NOP_WORD) |->
			!(ide.reg_write || ide.mem_to_reg || ide.mem_write))
		else $error("No-op in ID/EX carries a write enable");

endmodule

// File: execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       flush,
	input  cpu_pkg::fwd_sel_t          fwd_a,
	input  cpu_pkg::fwd_sel_t          fwd_b,
	id_ex_if.sink                      ide,
	wb_if.sink                         wb,
	input  logic [cpu_pkg::WORD_W-1:0] mem_value, // EX/MEM result for forwarding
	ex_mem_if.source                   exm,
	output logic                       branch_taken,
	output logic [cpu_pkg::WORD_W-1:0] branch_target
);

	localparam int W = cpu_pkg::WORD_W;

	cpu_pkg::opcode_t op;
	logic [W-1:0]     opa, opb;          // Forwarded operands
	logic [W-1:0]     sum, diff, sat, alu_out, ex_result;
	logic [W-1:0]     mem_addr, b_target;
	logic [3:0]       shamt;
	logic             add_ovf, sub_ovf, alu_ovf;
	logic             flag_z_we, flag_vn_we, cond;
	logic [2:0]       flags;

	assign op    = cpu_pkg::opcode_t'(ide.instr[15:12]);
	assign shamt = ide.instr[3:0];

	// --------------------------------------------------
	// Forwarding muxes
	// --------------------------------------------------
	assign opa = (fwd_a == cpu_pkg::FWD_MEM) ? mem_value :
		(fwd_a == cpu_pkg::FWD_WB) ? wb.value : ide.data_a;
	assign opb = (fwd_b == cpu_pkg::FWD_MEM) ? mem_value :
		(fwd_b == cpu_pkg::FWD_WB) ? wb.value : ide.data_b;

	// --------------------------------------------------
	// ALU
	// --------------------------------------------------
	assign sum     = opa + opb;
	assign diff    = opa - opb;
	assign add_ovf = (opa[W-1] == opb[W-1]) && (sum[W-1] != opa[W-1]);
	assign sub_ovf = (opa[W-1] != opb[W-1]) && (diff[W-1] != opa[W-1]);
	// Overflow always saturates toward the sign of A
	assign sat = opa[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};

	always_comb begin
		alu_out = '0;
		alu_ovf = 1'b0;
		case (op)
			cpu_pkg::ADD: begin
				alu_out = add_ovf ? sat : sum;
				alu_ovf = add_ovf;
			end
			cpu_pkg::SUB: begin
				alu_out = sub_ovf ? sat : diff;
				alu_ovf = sub_ovf;
			end
			cpu_pkg::XOR: alu_out = opa ^ opb;
			cpu_pkg::AND: alu_out = opa & opb;
			cpu_pkg::SLL: alu_out = opa << shamt;
			cpu_pkg::SRA: alu_out = $signed(opa) >>> shamt;
			cpu_pkg::ROR: alu_out = (opa >> shamt) | (opa << (W - shamt));
			default: ;
		endcase
	end

	always_comb begin
		case (op)
			cpu_pkg::LHB: ex_result = {ide.instr[7:0], opa[7:0]};
			cpu_pkg::LLB: ex_result = {opa[W-1:8], ide.instr[7:0]};
			cpu_pkg::PCS: ex_result = ide.pc_plus_2; // Next instruction address
			default:      ex_result = alu_out;
		endcase
	end

	// Base with bit 0 cleared plus doubled offset
	assign mem_addr = {opb[W-1:1], 1'b0} + {{(W-5){ide.instr[3]}}, ide.instr[3:0], 1'b0};

	// --------------------------------------------------
	// Flag register
	// --------------------------------------------------
	assign flag_z_we  = (ide.instr[15:12] <= 4'h6); // Any ALU op, not the no-op
	assign flag_vn_we = (op == cpu_pkg::ADD) || (op == cpu_pkg::SUB);

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else begin
			if (flag_z_we)
				flags[cpu_pkg::FLAG_Z] <= (alu_out == '0);
			if (flag_vn_we) begin
				flags[cpu_pkg::FLAG_V] <= alu_ovf;
				flags[cpu_pkg::FLAG_N] <= alu_out[W-1];
			end
		end
	end

	// --------------------------------------------------
	// Branch decision and target
	// --------------------------------------------------
	always_comb begin
		case (ide.instr[11:9])
			3'b000:  cond = !flags[cpu_pkg::FLAG_Z];                            // NE
			3'b001:  cond = flags[cpu_pkg::FLAG_Z];                             // EQ
			3'b010:  cond = !flags[cpu_pkg::FLAG_Z] && !flags[cpu_pkg::FLAG_N]; // GT
			3'b011:  cond = flags[cpu_pkg::FLAG_N];                             // LT
			3'b100:  cond = flags[cpu_pkg::FLAG_Z] || !flags[cpu_pkg::FLAG_N];  // GE
			3'b101:  cond = flags[cpu_pkg::FLAG_Z] || flags[cpu_pkg::FLAG_N];   // LE
			3'b110:  cond = flags[cpu_pkg::FLAG_V];                             // OV
			default: cond = 1'b1;                                               // Always
		endcase
	end

	assign b_target      = ide.pc_plus_2 + {{(W-10){ide.instr[8]}}, ide.instr[8:0], 1'b0};
	assign branch_target = (op == cpu_pkg::BR) ? opa : b_target;
	assign branch_taken  = ((op == cpu_pkg::B) || (op == cpu_pkg::BR)) && cond;

	// --------------------------------------------------
	// EX/MEM register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			exm.reg_write  <= 1'b0;
			exm.mem_to_reg <= 1'b0;
			exm.mem_write  <= 1'b0;
		end else begin
			exm.reg_write  <= ide.reg_write;
			exm.mem_to_reg <= ide.mem_to_reg;
			exm.mem_write  <= ide.mem_write;
		end
	end

	always_ff @(posedge clk) begin
		exm.result     <= ex_result;
		exm.store_data <= opa; // rd comes in on port 1 for SW
		exm.mem_addr   <= mem_addr;
		exm.rd_sel     <= ide.rd_sel;
	end

endmodule

// File: memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
	input  logic                       clk,
	input  logic                       rst,
	ex_mem_if.sink                     exm,
	input  logic [cpu_pkg::WORD_W-1:0] dmem_rdata,
	output logic [cpu_pkg::WORD_W-1:0] dmem_addr,
	output logic [cpu_pkg::WORD_W-1:0] dmem_wdata,
	output logic                       dmem_we,
	output logic                       dmem_re,
	wb_if.source                       wb
);

	logic [cpu_pkg::WORD_W-1:0] mem_value;

	// Strobes straight from EX/MEM
	assign dmem_addr  = exm.mem_addr;
	assign dmem_wdata = exm.store_data;
	assign dmem_we    = exm.mem_write;  // Write lands at the clock edge
	assign dmem_re    = exm.mem_to_reg;

	assign mem_value = exm.mem_to_reg ? dmem_rdata : exm.result;

	// --------------------------------------------------
	// MEM/WB register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			wb.reg_write <= 1'b0;
		else
			wb.reg_write <= exm.reg_write;
	end

	always_ff @(posedge clk) begin
		wb.rd_sel <= exm.rd_sel;
		wb.value  <= mem_value;
	end

	assert property (@(posedge clk) disable iff (rst) !(dmem_we && dmem_re))
		else $error("Data memory read and write in the same cycle");

endmodule

// File: hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit #(
	parameter int NUM_REGS = 16,
	parameter bit R0_ZERO  = 1'b1
) (
	input  logic                          clk,
	input  logic                          rst,
	id_ex_if.sink                         ide,
	ex_mem_if.sink                        exm,
	wb_if.sink                            wb,
	input  logic [cpu_pkg::REG_SEL_W-1:0] rs_sel,  // Sources of the instruction in ID
	input  logic [cpu_pkg::REG_SEL_W-1:0] rt_sel,
	input  logic                          branch_taken,
	input  cpu_pkg::opcode_t              id_op,
	output logic                          stall,
	output logic                          flush,
	output cpu_pkg::fwd_sel_t             fwd_a,
	output cpu_pkg::fwd_sel_t             fwd_b,
	output logic                          halted,
	output logic                          hlt
);

	localparam int IDX_W = $clog2(NUM_REGS);

	logic mem_wr, wb_wr, id_hlt;
	logic halted_q, hlt_mem_q, hlt_q;

	function automatic logic same_reg(
		input logic [cpu_pkg::REG_SEL_W-1:0] a,
		input logic [cpu_pkg::REG_SEL_W-1:0] b
	);
		return a[IDX_W-1:0] == b[IDX_W-1:0];
	endfunction

	// No forwarding of r0 writes while r0 reads as zero
	function automatic logic fwd_ok(input logic [cpu_pkg::REG_SEL_W-1:0] sel);
		return !R0_ZERO || (sel[IDX_W-1:0] != '0);
	endfunction

	// --------------------------------------------------
	// Forwarding, MEM before WB
	// --------------------------------------------------
	assign mem_wr = exm.reg_write && !exm.mem_to_reg && fwd_ok(exm.rd_sel); // Load data not ready
	assign wb_wr  = wb.reg_write && fwd_ok(wb.rd_sel);

	assign fwd_a = (mem_wr && same_reg(exm.rd_sel, ide.rs_sel)) ? cpu_pkg::FWD_MEM :
		(wb_wr && same_reg(wb.rd_sel, ide.rs_sel)) ? cpu_pkg::FWD_WB : cpu_pkg::FWD_REG;
	assign fwd_b = (mem_wr && same_reg(exm.rd_sel, ide.rt_sel)) ? cpu_pkg::FWD_MEM :
		(wb_wr && same_reg(wb.rd_sel, ide.rt_sel)) ? cpu_pkg::FWD_WB : cpu_pkg::FWD_REG;

	// Load in EX feeding the instruction in ID
	assign stall = ide.reg_write && ide.mem_to_reg &&
		(same_reg(ide.rd_sel, rs_sel) || same_reg(ide.rd_sel, rt_sel));
	assign flush = branch_taken;

	// --------------------------------------------------
	// Halt tracking
	// --------------------------------------------------
	assign id_hlt = (id_op == cpu_pkg::HLT) && !flush; // Wrong-path HLT ignored
	assign halted = halted_q || id_hlt;
	assign hlt    = hlt_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			halted_q  <= 1'b0;
			hlt_mem_q <= 1'b0;
			hlt_q     <= 1'b0;
		end else begin
			halted_q  <= halted;
			hlt_mem_q <= (cpu_pkg::opcode_t'(ide.instr[15:12]) == cpu_pkg::HLT); // HLT now in MEM
			hlt_q     <= hlt_q || hlt_mem_q; // Sticky from WB on
		end
	end

endmodule

// File: cpu.sv
`timescale 1ns/100ps

module cpu #(
	parameter int NUM_REGS = 16,
	parameter bit R0_ZERO  = 1'b1
) (
	input  logic                       clk,
	input  logic                       rst,
	output logic [cpu_pkg::WORD_W-1:0] imem_addr,
	input  logic [cpu_pkg::WORD_W-1:0] imem_data,
	output logic [cpu_pkg::WORD_W-1:0] dmem_addr,
	output logic [cpu_pkg::WORD_W-1:0] dmem_wdata,
	output logic                       dmem_we,
	output logic                       dmem_re,
	input  logic [cpu_pkg::WORD_W-1:0] dmem_rdata,
	output logic [cpu_pkg::WORD_W-1:0] pc_out,
	output logic                       hlt
);

	id_ex_if  id_ex ();
	ex_mem_if ex_mem ();
	wb_if     wb_bus ();

	logic                          stall, flush, halted, branch_taken;
	logic [cpu_pkg::WORD_W-1:0]    branch_target, if_pc_plus_2, if_instr;
	logic [cpu_pkg::REG_SEL_W-1:0] rs_sel, rt_sel;
	cpu_pkg::fwd_sel_t             fwd_a, fwd_b;

	// --------------------------------------------------
	// Pipeline stages
	// --------------------------------------------------
	fetch_stage fetch0 (
		.clk(clk), .rst(rst), .stall(stall), .flush(flush), .halted(halted),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.imem_data(imem_data), .imem_addr(imem_addr), .pc_out(pc_out),
		.if_pc_plus_2(if_pc_plus_2), .if_instr(if_instr)
	);

	decode_stage #(.NUM_REGS(NUM_REGS), .R0_ZERO(R0_ZERO)) decode0 (
		.clk(clk), .rst(rst), .stall(stall), .flush(flush),
		.if_pc_plus_2(if_pc_plus_2), .if_instr(if_instr),
		.wb(wb_bus.sink), .ide(id_ex.source), .rs_sel(rs_sel), .rt_sel(rt_sel)
	);

	execute_stage execute0 (
		.clk(clk), .rst(rst), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.ide(id_ex.sink), .wb(wb_bus.sink), .mem_value(ex_mem.result),
		.exm(ex_mem.source), .branch_taken(branch_taken), .branch_target(branch_target)
	);

	memory_stage memory0 (
		.clk(clk), .rst(rst), .exm(ex_mem.sink), .dmem_rdata(dmem_rdata),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_re(dmem_re), .wb(wb_bus.source)
	);

	// Stalls, forwarding selects and halt
	hazard_unit #(.NUM_REGS(NUM_REGS), .R0_ZERO(R0_ZERO)) hazard0 (
		.clk(clk), .rst(rst), .ide(id_ex.sink), .exm(ex_mem.sink), .wb(wb_bus.sink),
		.rs_sel(rs_sel), .rt_sel(rt_sel), .branch_taken(branch_taken),
		.id_op(cpu_pkg::opcode_t'(if_instr[15:12])),
		.stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.halted(halted), .hlt(hlt)
	);

endmodule

// File: cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

	localparam int W           = cpu_pkg::WORD_W;
	localparam int NUM_ROWS    = 27;
	localparam int ROW_CYCLES  = 64;  // Budget per row
	localparam int HALT_WAIT   = 40;  // Cycles from reset release to hlt
	localparam int POST_HALT   = 8;   // Cycles watched after hlt
	localparam int CYCLE_LIMIT = NUM_ROWS * ROW_CYCLES + 16;

	// Branch condition field
	localparam logic [2:0] COND_NE = 3'd0, COND_EQ = 3'd1, COND_GT = 3'd2, COND_LT = 3'd3;
	localparam logic [2:0] COND_GE = 3'd4, COND_OV = 3'd6, COND_AL = 3'd7;

	typedef struct packed {
		cpu_pkg::opcode_t op;
		logic [W-1:0]     a;
		logic [W-1:0]     b;    // Shift amount in b[3:0], byte in b[7:0]
		logic [2:0]       cond;
		logic [W-1:0]     exp;  // Word stored to address 6
		logic             rnd;  // Operands drawn at run time
	} row_t;

	logic         clk, rst;
	logic [W-1:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata, pc_out;
	logic         dmem_we, dmem_re, hlt;

	logic [W-1:0] imem [64];
	logic [W-1:0] dmem [64];
	logic [W-1:0] store_addr [$];  // Stores seen on the bus
	logic [W-1:0] store_data [$];
	logic [W-1:0] exp_addr [$];    // Stores the program should make
	logic [W-1:0] exp_data [$];
	logic [W-1:0] load_addr [$];   // Loads seen on the bus
	logic [W-1:0] exp_load [$];    // Loads the program should make
	row_t         rows [NUM_ROWS];
	int           seed, value_errors, other_errors, cycle_count, prog_len, cur_row;
	logic [31:0]  rnd_bits;

	cpu #(.NUM_REGS(16)) dut0 (
		.clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .pc_out(pc_out), .hlt(hlt)
	);

	// --------------------------------------------------
	// Memory models, zero-latency reads
	// --------------------------------------------------
	assign imem_data  = imem[imem_addr[6:1]];
	assign dmem_rdata = dmem[dmem_addr[6:1]];

	always @(posedge clk) begin
		if (dmem_we === 1'b1) begin
			dmem[dmem_addr[6:1]] <= dmem_wdata; // Write lands at the edge
			store_addr.push_back(dmem_addr);
			store_data.push_back(dmem_wdata);
		end
		if (dmem_re === 1'b1)
			load_addr.push_back(dmem_addr);
	end

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Run-length guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
			report_counts();
			$display("Verification failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// Encoders and reference model
	// --------------------------------------------------
	function automatic logic [W-1:0] pack_instr(input cpu_pkg::opcode_t op,
		input logic [3:0] f2, input logic [3:0] f1, input logic [3:0] f0);
		return {op, f2, f1, f0};
	endfunction

	function automatic logic [W-1:0] branch_instr(input cpu_pkg::opcode_t op,
		input logic [2:0] cond, input logic [8:0] low);
		return {op, cond, low};
	endfunction

	function automatic logic [W-1:0] sat16(input int v);
		if (v > 32767)
			return 16'h7fff;
		if (v < -32768)
			return 16'h8000;
		return v[15:0];
	endfunction

	function automatic logic [W-1:0] ref_result(input cpu_pkg::opcode_t op,
		input logic [W-1:0] a, input logic [W-1:0] b);
		int sa, sb;
		logic [3:0] n;
		sa = $signed(a);
		sb = $signed(b);
		n  = b[3:0];
		case (op)
			cpu_pkg::ADD: return sat16(sa + sb);
			cpu_pkg::SUB: return sat16(sa - sb);
			cpu_pkg::XOR: return a ^ b;
			cpu_pkg::AND: return a & b;
			cpu_pkg::SLL: return a << n;
			cpu_pkg::SRA: return $signed(a) >>> n;
			cpu_pkg::ROR: return (n == 0) ? a : ((a >> n) | (a << (16 - n)));
			cpu_pkg::LHB: return {b[7:0], a[7:0]};
			cpu_pkg::LLB: return {a[15:8], b[7:0]};
			default:      return '0;
		endcase
	endfunction

	// Flags from SUB a, b then the condition test
	function automatic logic ref_taken(input logic [2:0] cond,
		input logic [W-1:0] a, input logic [W-1:0] b);
		int d;
		logic [W-1:0] r;
		logic z, v, n;
		d = $signed(a) - $signed(b);
		r = sat16(d);
		z = (r == '0);
		v = (d > 32767) || (d < -32768);
		n = r[15];
		case (cond)
			COND_NE: return !z;
			COND_EQ: return z;
			COND_GT: return !z && !n;
			COND_LT: return n;
			COND_GE: return z || !n;
			3'd5:    return z || n;   // LE
			COND_OV: return v;
			default: return 1'b1;
		endcase
	endfunction

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic check_word(input string name, input logic [cpu_pkg::WORD_W-1:0] got,
		input logic [cpu_pkg::WORD_W-1:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] time %0t row %0d %s: got %h, expected %h",
				$time, cur_row, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] time %0t row %0d %s: got %b, expected %b",
				$time, cur_row, name, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
	endtask

	// --------------------------------------------------
	// Program builder
	// --------------------------------------------------
	task automatic emit(input logic [W-1:0] word);
		imem[prog_len] <= word;
		prog_len++;
	endtask

	task automatic expect_store(input logic [W-1:0] addr, input logic [W-1:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic build_program(input int r);
		row_t row;
		row = rows[r];
		for (int i = 0; i < 64; i++)
			imem[i] <= 16'hf000 | i[15:0]; // HLT words tagged with their index
		prog_len = 0;
		exp_addr.delete();
		exp_data.delete();
		exp_load.delete();
		// Interleaved so LHB takes rd from WB and the op takes MEM and WB
		emit(pack_instr(cpu_pkg::LLB, 4'd1, row.a[7:4], row.a[3:0]));
		emit(pack_instr(cpu_pkg::LLB, 4'd2, row.b[7:4], row.b[3:0]));
		emit(pack_instr(cpu_pkg::LHB, 4'd1, row.a[15:12], row.a[11:8]));
		emit(pack_instr(cpu_pkg::LHB, 4'd2, row.b[15:12], row.b[11:8]));
		case (row.op)
			cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR:
				emit(pack_instr(row.op, 4'd3, 4'd1, row.b[3:0]));
			cpu_pkg::LHB, cpu_pkg::LLB: begin
				emit(pack_instr(row.op, 4'd1, row.b[7:4], row.b[3:0]));
				emit(pack_instr(cpu_pkg::ADD, 4'd3, 4'd1, 4'd0)); // r3 = r1 + r0
			end
			cpu_pkg::LW: begin
				emit(pack_instr(cpu_pkg::SW, 4'd1, 4'd0, 4'd1));  // A to address 2
				expect_store(16'd2, row.a);
				emit(pack_instr(cpu_pkg::LW, 4'd4, 4'd0, 4'd1));
				exp_load.push_back(16'd2);
				emit(pack_instr(cpu_pkg::ADD, 4'd3, 4'd4, 4'd2)); // Load-use, one bubble
			end
			cpu_pkg::PCS: emit(pack_instr(cpu_pkg::PCS, 4'd3, 4'd0, 4'd0));
			cpu_pkg::B, cpu_pkg::BR: begin
				if (row.op == cpu_pkg::BR) begin
					emit(pack_instr(cpu_pkg::LLB, 4'd5, 4'h1, 4'h4)); // Target 0x14
					emit(pack_instr(cpu_pkg::LHB, 4'd5, 4'h0, 4'h0));
				end
				emit(pack_instr(cpu_pkg::SUB, 4'd3, 4'd1, 4'd2));
				if (row.op == cpu_pkg::BR)
					emit(branch_instr(cpu_pkg::BR, row.cond, {1'b0, 4'd5, 4'd0}));
				else
					emit(branch_instr(cpu_pkg::B, row.cond, 9'd2)); // Skip two
				emit(pack_instr(cpu_pkg::SW, 4'd1, 4'd0, 4'd4)); // Marker at 8
				emit(pack_instr(cpu_pkg::SW, 4'd2, 4'd0, 4'd5)); // Marker at 10
				if (!ref_taken(row.cond, row.a, row.b)) begin
					expect_store(16'd8, row.a);
					expect_store(16'd10, row.b);
				end
			end
			default: emit(pack_instr(row.op, 4'd3, 4'd1, 4'd2)); // Register ALU ops
		endcase
		emit(pack_instr(cpu_pkg::SW, 4'd3, 4'd0, 4'd3)); // Result to address 6
		expect_store(16'd6, row.exp);
		emit(16'hf000);
	endtask

	// --------------------------------------------------
	// Row runner
	// --------------------------------------------------
	task automatic compare_stores();
		int n;
		if (store_addr.size() != exp_addr.size()) begin
			other_errors++;
			$display("Row %0d: %0d data stores seen, %0d expected",
				cur_row, store_addr.size(), exp_addr.size());
		end
		n = (store_addr.size() < exp_addr.size()) ? store_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			check_word("dmem_addr", store_addr[i], exp_addr[i]);
			check_word("dmem_wdata", store_data[i], exp_data[i]);
		end
	endtask

	task automatic compare_loads();
		if (load_addr.size() != exp_load.size()) begin
			other_errors++;
			$display("Row %0d: %0d data loads seen, %0d expected",
				cur_row, load_addr.size(), exp_load.size());
		end else begin
			foreach (load_addr[i])
				check_word("dmem_addr", load_addr[i], exp_load[i]);
		end
	endtask

	task automatic run_row(input int r);
		int waited;
		logic [W-1:0] pc_hold;
		cur_row = r;
		@(posedge clk);
		rst <= 1'b1;
		store_addr.delete();
		store_data.delete();
		load_addr.delete();
		build_program(r);
		repeat (2) @(posedge clk);
		// Outputs after two reset cycles
		check_word("pc_out", pc_out, '0);
		check_word("imem_addr", imem_addr, '0);
		check_bit("dmem_we", dmem_we, 1'b0);
		check_bit("dmem_re", dmem_re, 1'b0);
		check_bit("hlt", hlt, 1'b0);
		rst <= 1'b0;
		waited = 0;
		while (hlt !== 1'b1 && waited < HALT_WAIT) begin
			@(posedge clk);
			waited++;
		end
		if (hlt !== 1'b1) begin
			other_errors++;
			$display("Row %0d: core did not halt within %0d cycles", r, HALT_WAIT);
		end else begin
			pc_hold = W'(2 * prog_len); // PC parks on the word after HLT
			repeat (POST_HALT) begin // Core must stay frozen
				@(posedge clk);
				check_bit("hlt", hlt, 1'b1);
				check_word("pc_out", pc_out, pc_hold);
				check_word("imem_addr", imem_addr, pc_hold);
				check_bit("dmem_we", dmem_we, 1'b0);
				check_bit("dmem_re", dmem_re, 1'b0);
			end
			compare_stores();
			compare_loads();
		end
	endtask

	task automatic load_table();
		rows[0]  = '{cpu_pkg::ADD, 16'h1234, 16'h0101, 3'd0, 16'h1335, 1'b0};
		rows[1]  = '{cpu_pkg::ADD, 16'h7000, 16'h2000, 3'd0, 16'h7fff, 1'b0}; // Saturates
		rows[2]  = '{cpu_pkg::SUB, 16'h0005, 16'h0007, 3'd0, 16'hfffe, 1'b0};
		rows[3]  = '{cpu_pkg::SUB, 16'h8000, 16'h0001, 3'd0, 16'h8000, 1'b0};
		rows[4]  = '{cpu_pkg::XOR, 16'hf0f0, 16'h3c3c, 3'd0, 16'hcccc, 1'b0};
		rows[5]  = '{cpu_pkg::AND, 16'hf0f0, 16'h3c3c, 3'd0, 16'h3030, 1'b0};
		rows[6]  = '{cpu_pkg::SLL, 16'h0123, 16'h0004, 3'd0, 16'h1230, 1'b0};
		rows[7]  = '{cpu_pkg::SRA, 16'h8421, 16'h0004, 3'd0, 16'hf842, 1'b0};
		rows[8]  = '{cpu_pkg::ROR, 16'h1234, 16'h0004, 3'd0, 16'h4123, 1'b0};
		rows[9]  = '{cpu_pkg::LHB, 16'h1234, 16'h00ab, 3'd0, 16'hab34, 1'b0};
		rows[10] = '{cpu_pkg::LLB, 16'h1234, 16'h00cd, 3'd0, 16'h12cd, 1'b0};
		rows[11] = '{cpu_pkg::ADD, 16'h0000, 16'h0000, 3'd0, 16'h0000, 1'b1};
		rows[12] = '{cpu_pkg::SUB, 16'h0000, 16'h0000, 3'd0, 16'h0000, 1'b1};
		rows[13] = '{cpu_pkg::SRA, 16'h0000, 16'h0000, 3'd0, 16'h0000, 1'b1};
		rows[14] = '{cpu_pkg::ROR, 16'h0000, 16'h0000, 3'd0, 16'h0000, 1'b1};
		rows[15] = '{cpu_pkg::LW,  16'h4000, 16'h3000, 3'd0, 16'h7000, 1'b0};
		rows[16] = '{cpu_pkg::LW,  16'h7ff0, 16'h0100, 3'd0, 16'h7fff, 1'b0};
		rows[17] = '{cpu_pkg::PCS, 16'h0000, 16'h0000, 3'd0, 16'h000a, 1'b0}; // PCS at 8
		rows[18] = '{cpu_pkg::B,   16'h0005, 16'h0005, COND_EQ, 16'h0000, 1'b0};
		rows[19] = '{cpu_pkg::B,   16'h0005, 16'h0005, COND_NE, 16'h0000, 1'b0};
		rows[20] = '{cpu_pkg::B,   16'h0003, 16'h0009, COND_LT, 16'hfffa, 1'b0};
		rows[21] = '{cpu_pkg::B,   16'h0003, 16'h0009, COND_GT, 16'hfffa, 1'b0};
		rows[22] = '{cpu_pkg::B,   16'h8000, 16'h0001, COND_OV, 16'h8000, 1'b0};
		rows[23] = '{cpu_pkg::B,   16'h0000, 16'h0000, COND_AL, 16'h0000, 1'b0};
		rows[24] = '{cpu_pkg::BR,  16'h0010, 16'h0001, COND_AL, 16'h000f, 1'b0};
		rows[25] = '{cpu_pkg::BR,  16'h0010, 16'h0001, COND_EQ, 16'h000f, 1'b0};
		rows[26] = '{cpu_pkg::BR,  16'h0009, 16'h0003, COND_GE, 16'h0006, 1'b0};
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		rst          = 1'b1;
		seed         = 31146;
		value_errors = 0;
		other_errors = 0;
		cycle_count  = 0;
		prog_len     = 0;
		cur_row      = 0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = 16'hf000 | i[15:0];
			dmem[i] = i[15:0] ^ 16'h5a5a; // Address-tagged fill
		end
		load_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (rows[r].rnd) begin
				rnd_bits    = $random(seed);
				rows[r].a   = rnd_bits[15:0];
				rnd_bits    = $random(seed);
				rows[r].b   = rnd_bits[15:0];
				rows[r].exp = ref_result(rows[r].op, rows[r].a, rows[r].b);
			end
			run_row(r);
		end
		report_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: compile.f
cpu_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
cpu.sv
cpu_tb.sv
